//--- sources.f
common/ic_cfg_pkg.sv
common/ic_ecc_pkg.sv
common/ic_mem_if.sv
ic_data/ic_data.sv
src/ic_data_array.sv
src/ic_data_wrapper.sv
bench/ic_data_assert.sv
bench/ic_data_tb.sv

//--- Bender.yml
package:
  name: ic_data

sources:
  - common/ic_cfg_pkg.sv
  - common/ic_ecc_pkg.sv
  - common/ic_mem_if.sv
  - ic_data/ic_data.sv
  - src/ic_data_array.sv
  - src/ic_data_wrapper.sv
  - target: test
    files:
      - bench/ic_data_assert.sv
      - bench/ic_data_tb.sv

//--- bench/ic_data_tb.sv
module ic_data_tb;
  import ic_cfg_pkg::*;
  import ic_ecc_pkg::*;

  localparam int unsigned NUM_WAYS     = 2;
  localparam int unsigned NUM_BANKS    = 2;
  localparam int unsigned INDEX_BITS   = 6;
  localparam int unsigned RESET_CYCLES = 4;

  typedef enum logic [1:0] {OP_FILL, OP_READ, OP_DWR, OP_DRD} op_kind_e;
  typedef enum logic [1:0] {SRC_CLEAN, SRC_RAW, SRC_FLIP} src_e;  // Debug write data

  typedef struct packed {
    op_kind_e              kind;
    logic                  way;
    logic [INDEX_BITS-1:0] index;
    logic                  bank;
    logic [NUM_WAYS-1:0]   hit;
    logic                  premux;
    src_e                  src;
    logic [6:0]            flip;     // Bit flipped by SRC_FLIP
    logic [NUM_BANKS-1:0]  exp_err;
  } op_t;

  logic                     clk;
  logic                     reset;
  logic [31:1]              ic_rw_addr;
  logic [NUM_WAYS-1:0]      ic_wr_en;
  logic                     ic_rd_en;
  ic_word_t [NUM_BANKS-1:0] ic_wr_data;
  ic_data_t                 ic_rd_data;
  ic_word_t                 ic_debug_wr_data;
  ic_word_t                 ic_debug_rd_data;
  logic [NUM_BANKS-1:0]     ic_eccerr;
  logic [INDEX_BITS+3:3]    ic_debug_addr;
  logic                     ic_debug_rd_en;
  logic                     ic_debug_wr_en;
  logic [NUM_WAYS-1:0]      ic_debug_way;
  ic_data_t                 ic_premux_data;
  logic                     ic_sel_premux_data;
  logic [NUM_WAYS-1:0]      ic_rd_hit;

  op_t      ops[$];
  ic_word_t shadow [NUM_WAYS][NUM_BANKS][1 << INDEX_BITS];  // Expected array contents
  ic_word_t last_dbg_word = '0;                              // Held debug read data
  logic [15:0] lfsr_state = 16'd40372;
  int       cycle_count = 0;
  int       cycle_limit = 0;

  ic_data_wrapper #(
    .NUM_WAYS   (NUM_WAYS),
    .NUM_BANKS  (NUM_BANKS),
    .INDEX_BITS (INDEX_BITS)
  ) u_ic_data_wrapper (
    .clk                (clk),
    .reset              (reset),
    .ic_rw_addr         (ic_rw_addr),
    .ic_wr_en           (ic_wr_en),
    .ic_rd_en           (ic_rd_en),
    .ic_wr_data         (ic_wr_data),
    .ic_rd_data         (ic_rd_data),
    .ic_debug_wr_data   (ic_debug_wr_data),
    .ic_debug_rd_data   (ic_debug_rd_data),
    .ic_eccerr          (ic_eccerr),
    .ic_debug_addr      (ic_debug_addr),
    .ic_debug_rd_en     (ic_debug_rd_en),
    .ic_debug_wr_en     (ic_debug_wr_en),
    .ic_debug_way       (ic_debug_way),
    .ic_premux_data     (ic_premux_data),
    .ic_sel_premux_data (ic_sel_premux_data),
    .ic_rd_hit          (ic_rd_hit)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the test did not finish within %0d cycles", cycle_limit);
      $display("STATUS: FAIL");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic ic_word_t rand_bits(input int n);
    ic_word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v[i] = lfsr_state[0];
    end
    return v;
  endfunction

  function automatic logic [31:1] make_addr(input logic [INDEX_BITS-1:0] index,
                                            input logic bank);
    logic [31:1] a;
    a = '0;
    a[IC_BANK_BIT] = bank;
    a[IC_INDEX_LO +: INDEX_BITS] = index;
    return a;
  endfunction

  task automatic check_data(input ic_data_t got, input ic_data_t exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s read data %h, expected %h", $time, what, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "read data mismatch");
    end
  endtask

  task automatic check_word(input ic_word_t got, input ic_word_t exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s debug word %h, expected %h", $time, what, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "debug word mismatch");
    end
  endtask

  task automatic check_err(input logic [NUM_BANKS-1:0] got, input logic [NUM_BANKS-1:0] exp,
                           input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s eccerr %b, expected %b", $time, what, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "eccerr mismatch");
    end
  endtask

  task automatic check_assertions();
    if (u_ic_data_wrapper.u_ic_data.u_ic_data_assert.fail_count != 0) begin
      $display("A bound assertion on ic_data failed, see the error above");
      $display("STATUS: FAIL");
      $fatal(1, "assertion failure");
    end
  endtask

  function automatic void add_op(input op_kind_e kind, input logic way,
                                 input logic [INDEX_BITS-1:0] index, input logic bank,
                                 input logic [NUM_WAYS-1:0] hit, input logic premux,
                                 input src_e src, input logic [6:0] flip,
                                 input logic [NUM_BANKS-1:0] exp_err);
    op_t op;
    op = '{kind, way, index, bank, hit, premux, src, flip, exp_err};
    ops.push_back(op);
  endfunction

  // kind, way, index, bank, hit, premux, source, flip bit, expected eccerr
  function automatic void build_table();
    add_op(OP_FILL, 0, 3, 0, 2'b00, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_FILL, 1, 3, 0, 2'b00, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_FILL, 0, 17, 0, 2'b00, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_FILL, 1, 42, 0, 2'b00, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_FILL, 0, 63, 0, 2'b00, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_READ, 0, 3, 0, 2'b01, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_READ, 0, 3, 1, 2'b01, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_READ, 0, 3, 0, 2'b10, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_READ, 0, 3, 1, 2'b10, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_READ, 0, 17, 1, 2'b01, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_READ, 0, 42, 0, 2'b10, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_READ, 0, 63, 1, 2'b01, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_READ, 0, 17, 0, 2'b01, 1, SRC_CLEAN, 0, 2'b00);  // Premux wins over hit
    add_op(OP_READ, 0, 42, 1, 2'b00, 1, SRC_CLEAN, 0, 2'b00);
    add_op(OP_DWR, 1, 20, 1, 2'b00, 0, SRC_RAW, 0, 2'b00);
    add_op(OP_DRD, 1, 20, 1, 2'b00, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_DWR, 0, 20, 0, 2'b00, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_DRD, 0, 20, 0, 2'b00, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_DRD, 1, 42, 0, 2'b00, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_DRD, 0, 63, 1, 2'b00, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_FILL, 0, 9, 0, 2'b00, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_FILL, 1, 9, 0, 2'b00, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_DWR, 0, 9, 1, 2'b00, 0, SRC_FLIP, 37, 2'b00);
    add_op(OP_READ, 0, 9, 1, 2'b01, 0, SRC_CLEAN, 0, 2'b10);
    add_op(OP_READ, 0, 9, 0, 2'b01, 0, SRC_CLEAN, 0, 2'b10);
    add_op(OP_READ, 0, 9, 1, 2'b10, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_READ, 0, 9, 1, 2'b00, 0, SRC_CLEAN, 0, 2'b00);  // Miss masks the flag
    add_op(OP_READ, 0, 9, 1, 2'b01, 1, SRC_CLEAN, 0, 2'b00);
    add_op(OP_DWR, 1, 9, 0, 2'b00, 0, SRC_FLIP, 0, 2'b00);
    add_op(OP_READ, 0, 9, 0, 2'b10, 0, SRC_CLEAN, 0, 2'b01);
    add_op(OP_FILL, 1, 30, 0, 2'b00, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_FILL, 0, 30, 0, 2'b00, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_DWR, 0, 30, 1, 2'b00, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_READ, 0, 30, 0, 2'b10, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_READ, 0, 30, 1, 2'b10, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_DRD, 1, 30, 1, 2'b00, 0, SRC_CLEAN, 0, 2'b00);
    add_op(OP_READ, 0, 30, 1, 2'b01, 0, SRC_CLEAN, 0, 2'b00);
  endfunction

  task automatic set_idle();
    ic_wr_en           <= '0;
    ic_rd_en           <= 1'b0;
    ic_debug_rd_en     <= 1'b0;
    ic_debug_wr_en     <= 1'b0;
    ic_rd_hit          <= '0;
    ic_sel_premux_data <= 1'b0;
  endtask

  // Request cycle, then the data cycle with hit and premux
  task automatic run_op(input op_t op, input int num);
    ic_word_t                 w;
    ic_data_t                 d;
    ic_word_t [NUM_BANKS-1:0] fill;
    ic_data_t                 premux_val;
    ic_data_t                 exp_data;
    string                    tag;
    tag = $sformatf("op %0d", num);
    premux_val = '0;
    @(posedge clk);
    set_idle();
    case (op.kind)
      OP_FILL: begin
        for (int b = 0; b < NUM_BANKS; b++) begin
          w = rand_bits(IC_DATA_W);
          d = w[IC_DATA_W-1:0];
          fill[b] = {ic_ecc_encode(d), d};
          shadow[op.way][b][op.index] = fill[b];
        end
        ic_rw_addr <= make_addr(op.index, op.bank);
        ic_wr_data <= fill;
        ic_wr_en   <= 2'b01 << op.way;
      end
      OP_READ: begin
        w = rand_bits(IC_DATA_W);
        premux_val = w[IC_DATA_W-1:0];
        ic_rw_addr <= make_addr(op.index, op.bank);
        ic_rd_en   <= 1'b1;
      end
      OP_DWR: begin
        case (op.src)
          SRC_CLEAN: begin
            w = rand_bits(IC_DATA_W);
            d = w[IC_DATA_W-1:0];
            w = {ic_ecc_encode(d), d};
          end
          SRC_RAW: w = rand_bits(IC_WORD_W);  // Check bits random too
          default: begin
            w = shadow[op.way][op.bank][op.index];
            w[op.flip] = ~w[op.flip];
          end
        endcase
        shadow[op.way][op.bank][op.index] = w;
        ic_debug_addr    <= {op.index, op.bank};
        ic_debug_way     <= 2'b01 << op.way;
        ic_debug_wr_data <= w;
        ic_debug_wr_en   <= 1'b1;
      end
      default: begin
        ic_debug_addr  <= {op.index, op.bank};
        ic_debug_way   <= 2'b01 << op.way;
        ic_debug_rd_en <= 1'b1;
      end
    endcase
    @(posedge clk);
    set_idle();
    if (op.kind == OP_READ) begin
      ic_rd_hit          <= op.hit;
      ic_sel_premux_data <= op.premux;
      ic_premux_data     <= premux_val;
    end
    @(negedge clk);
    check_assertions();
    if (op.kind == OP_READ) begin
      if (op.premux) begin
        exp_data = premux_val;
      end else if (op.hit == '0) begin
        exp_data = '0;  // Nothing selected
      end else begin
        exp_data = shadow[op.hit[1]][op.bank][op.index][IC_DATA_W-1:0];
      end
      check_data(ic_rd_data, exp_data, tag);
      check_err(ic_eccerr, op.exp_err, tag);
    end else begin
      if (op.kind == OP_DRD) begin
        last_dbg_word = shadow[op.way][op.bank][op.index];
      end
      check_err(ic_eccerr, '0, tag);
    end
    check_word(ic_debug_rd_data, last_dbg_word, tag);
  endtask

  initial begin
    reset            <= 1'b1;
    ic_rw_addr       <= '0;
    ic_wr_data       <= '0;
    ic_debug_wr_data <= '0;
    ic_debug_addr    <= '0;
    ic_debug_way     <= '0;
    ic_premux_data   <= '0;
    set_idle();
    build_table();
    cycle_limit = 2 * (2 * ops.size()) + RESET_CYCLES + 16;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_err(ic_eccerr, '0, "after reset");
    check_word(ic_debug_rd_data, '0, "after reset");
    for (int i = 0; i < ops.size(); i++) begin
      run_op(ops[i], i);
    end
    @(negedge clk);
    check_assertions();  // Last data cycle
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- bench/ic_data_assert.sv
module ic_data_assert #(
  parameter int unsigned NUM_WAYS  = 2,
  parameter int unsigned NUM_BANKS = 2
) (
  input logic                 clk,
  input logic                 reset,
  input logic [NUM_WAYS-1:0]  ic_wr_en,
  input logic                 ic_rd_en,
  input logic                 ic_debug_rd_en,
  input logic                 ic_debug_wr_en,
  input logic [NUM_BANKS-1:0] ic_eccerr
);

  int unsigned fail_count = 0;  // Read by the testbench

  assert property (@(posedge clk) disable iff (reset) ic_rd_en |-> $onehot0(ic_wr_en))
    else begin
      fail_count++;
      $error("fill way strobes not one-hot or zero during a read");
    end

  // Fill, read and both debug strobes share the bank address
  assert property (@(posedge clk) disable iff (reset)
                   $onehot0({|ic_wr_en, ic_rd_en, ic_debug_rd_en, ic_debug_wr_en}))
    else begin
      fail_count++;
      $error("more than one fill, read or debug operation in one cycle");
    end

  // Read data and its flags are due one cycle after the request
  assert property (@(posedge clk) disable iff (reset) !$past(ic_rd_en) |-> (ic_eccerr == '0))
    else begin
      fail_count++;
      $error("ECC error flagged without read data in flight");
    end

endmodule

bind ic_data ic_data_assert #(
  .NUM_WAYS  (NUM_WAYS),
  .NUM_BANKS (NUM_BANKS)
) u_ic_data_assert (
  .clk            (clk),
  .reset          (reset),
  .ic_wr_en       (ic_wr_en),
  .ic_rd_en       (ic_rd_en),
  .ic_debug_rd_en (ic_debug_rd_en),
  .ic_debug_wr_en (ic_debug_wr_en),
  .ic_eccerr      (ic_eccerr)
);

//--- src/ic_data_wrapper.sv
module ic_data_wrapper #(
  parameter int unsigned NUM_WAYS   = ic_cfg_pkg::IC_NUM_WAYS,
  parameter int unsigned NUM_BANKS  = ic_cfg_pkg::IC_NUM_BANKS,
  parameter int unsigned INDEX_BITS = ic_cfg_pkg::IC_INDEX_BITS
) (
  input  logic                                  clk,
  input  logic                                  reset,

  input  logic [31:1]                           ic_rw_addr,
  input  logic [NUM_WAYS-1:0]                   ic_wr_en,     // Fill way strobes
  input  logic                                  ic_rd_en,
  input  ic_cfg_pkg::ic_word_t [NUM_BANKS-1:0]  ic_wr_data,   // Fill words with ECC
  output ic_cfg_pkg::ic_data_t                  ic_rd_data,   // One cycle after rd_en

  input  ic_cfg_pkg::ic_word_t                  ic_debug_wr_data,
  output ic_cfg_pkg::ic_word_t                  ic_debug_rd_data,
  output logic [NUM_BANKS-1:0]                  ic_eccerr,    // Per bank error flag
  input  logic [INDEX_BITS+3:3]                 ic_debug_addr,
  input  logic                                  ic_debug_rd_en,
  input  logic                                  ic_debug_wr_en,
  input  logic [NUM_WAYS-1:0]                   ic_debug_way,

  input  ic_cfg_pkg::ic_data_t                  ic_premux_data,
  input  logic                                  ic_sel_premux_data,
  input  logic [NUM_WAYS-1:0]                   ic_rd_hit     // Sampled in data cycle
);

  ic_mem_if #(
    .NUM_WAYS   (NUM_WAYS),
    .NUM_BANKS  (NUM_BANKS),
    .INDEX_BITS (INDEX_BITS)
  ) u_mem_if ();

  ic_data #(
    .NUM_WAYS   (NUM_WAYS),
    .NUM_BANKS  (NUM_BANKS),
    .INDEX_BITS (INDEX_BITS)
  ) u_ic_data (
    .clk                (clk),
    .reset              (reset),
    .ic_rw_addr         (ic_rw_addr),
    .ic_wr_en           (ic_wr_en),
    .ic_rd_en           (ic_rd_en),
    .ic_wr_data         (ic_wr_data),
    .ic_rd_data         (ic_rd_data),
    .ic_debug_wr_data   (ic_debug_wr_data),
    .ic_debug_rd_data   (ic_debug_rd_data),
    .ic_eccerr          (ic_eccerr),
    .ic_debug_addr      (ic_debug_addr),
    .ic_debug_rd_en     (ic_debug_rd_en),
    .ic_debug_wr_en     (ic_debug_wr_en),
    .ic_debug_way       (ic_debug_way),
    .ic_premux_data     (ic_premux_data),
    .ic_sel_premux_data (ic_sel_premux_data),
    .ic_rd_hit          (ic_rd_hit),
    .mem                (u_mem_if.ctrl)
  );

  ic_data_array #(
    .NUM_WAYS   (NUM_WAYS),
    .NUM_BANKS  (NUM_BANKS),
    .INDEX_BITS (INDEX_BITS)
  ) u_ic_data_array (
    .clk (clk),
    .mem (u_mem_if.array)
  );

endmodule

//--- src/ic_data_array.sv
module ic_data_array #(
  parameter int unsigned NUM_WAYS   = 2,
  parameter int unsigned NUM_BANKS  = 2,
  parameter int unsigned INDEX_BITS = 6
) (
  input  logic    clk,
  ic_mem_if.array mem
);
  import ic_cfg_pkg::*;

  localparam int unsigned DEPTH = 2 ** INDEX_BITS;  // Rows per bank

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      ic_word_t ram [DEPTH];
      ic_word_t rd_q;

      always_ff @(posedge clk) begin
        if (mem.bank_wren[b][w]) begin
          ram[mem.bank_addr[b]] <= mem.bank_wr_data[b];
        end
      end

      // Read on any cycle the bank is not being written
      always_ff @(posedge clk) begin
        if (!(|mem.bank_wren[b])) begin
          rd_q <= ram[mem.bank_addr[b]];
        end
      end

      assign mem.bank_rd_data[w][b] = rd_q;
    end
  end

endmodule

//--- ic_data/ic_data.sv
module ic_data #(
  parameter int unsigned NUM_WAYS   = 2,
  parameter int unsigned NUM_BANKS  = 2,
  parameter int unsigned INDEX_BITS = 6
) (
  input  logic                                  clk,
  input  logic                                  reset,

  input  logic [31:1]                           ic_rw_addr,
  input  logic [NUM_WAYS-1:0]                   ic_wr_en,
  input  logic                                  ic_rd_en,
  input  ic_cfg_pkg::ic_word_t [NUM_BANKS-1:0]  ic_wr_data,
  output ic_cfg_pkg::ic_data_t                  ic_rd_data,

  input  ic_cfg_pkg::ic_word_t                  ic_debug_wr_data,
  output ic_cfg_pkg::ic_word_t                  ic_debug_rd_data,
  output logic [NUM_BANKS-1:0]                  ic_eccerr,
  input  logic [INDEX_BITS+3:3]                 ic_debug_addr,
  input  logic                                  ic_debug_rd_en,
  input  logic                                  ic_debug_wr_en,
  input  logic [NUM_WAYS-1:0]                   ic_debug_way,

  input  ic_cfg_pkg::ic_data_t                  ic_premux_data,
  input  logic                                  ic_sel_premux_data,
  input  logic [NUM_WAYS-1:0]                   ic_rd_hit,

  ic_mem_if.ctrl                                mem
);
  import ic_cfg_pkg::*;
  import ic_ecc_pkg::*;

  logic [INDEX_BITS-1:0] rw_index;
  logic [INDEX_BITS-1:0] dbg_index;
  logic                  rw_bank;
  logic                  dbg_bank;
  logic                  dbg_access;

  logic                  rd_valid_q;   // Read data due this cycle
  logic                  rd_bank_q;
  logic                  dbg_rd_q;     // Debug word due this cycle
  logic [NUM_WAYS-1:0]   dbg_way_q;
  logic                  dbg_bank_q;
  ic_word_t              dbg_rd_data_q;

  ic_word_t [NUM_BANKS-1:0] hit_word;  // Hit way word of each bank
  ic_word_t                 dbg_word;
  logic                     hit_any;

  // Address split
  assign rw_index  = ic_rw_addr[IC_INDEX_LO +: INDEX_BITS];
  assign rw_bank   = ic_rw_addr[IC_BANK_BIT];
  assign dbg_index = ic_debug_addr[IC_INDEX_LO +: INDEX_BITS];
  assign dbg_bank  = ic_debug_addr[IC_BANK_BIT];

  assign dbg_access = ic_debug_rd_en | ic_debug_wr_en;

  // Both banks share one row, debug takes over the address
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      mem.bank_addr[b] = dbg_access ? dbg_index : rw_index;
    end
  end

  // Fill writes every bank of the chosen ways, debug only one bank
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (ic_debug_wr_en) begin
        mem.bank_wren[b]    = (dbg_bank == b) ? ic_debug_way : '0;
        mem.bank_wr_data[b] = ic_debug_wr_data;  // Raw, check bits as given
      end else begin
        mem.bank_wren[b]    = ic_wr_en;
        mem.bank_wr_data[b] = ic_wr_data[b];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid_q <= 1'b0;
      rd_bank_q  <= 1'b0;
      dbg_rd_q   <= 1'b0;
      dbg_way_q  <= '0;
      dbg_bank_q <= 1'b0;
    end else begin
      rd_valid_q <= ic_rd_en;
      dbg_rd_q   <= ic_debug_rd_en;
      if (ic_rd_en) begin
        rd_bank_q <= rw_bank;
      end
      if (ic_debug_rd_en) begin
        dbg_way_q  <= ic_debug_way;
        dbg_bank_q <= dbg_bank;
      end
    end
  end

  // One-hot way select, zero when nothing hits
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      hit_word[b] = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (ic_rd_hit[w]) begin
          hit_word[b] = hit_word[b] | mem.bank_rd_data[w][b];
        end
      end
    end
  end

  assign hit_any = |ic_rd_hit;

  assign ic_rd_data = ic_sel_premux_data ? ic_premux_data
                                         : hit_word[rd_bank_q][IC_DATA_W-1:0];

  // Flag only, the fetch unit refetches on error
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      ic_eccerr[b] = rd_valid_q & hit_any & ~ic_sel_premux_data &
                     (ic_ecc_syndrome(hit_word[b]) != '0);
    end
  end

  // Debug read path
  always_comb begin
    dbg_word = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (dbg_way_q[w]) begin
        dbg_word = dbg_word | mem.bank_rd_data[w][dbg_bank_q];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dbg_rd_data_q <= '0;
    end else if (dbg_rd_q) begin
      dbg_rd_data_q <= dbg_word;  // Hold until next debug read
    end
  end

  assign ic_debug_rd_data = dbg_rd_q ? dbg_word : dbg_rd_data_q;

endmodule

//--- common/ic_mem_if.sv
interface ic_mem_if #(
  parameter int unsigned NUM_WAYS   = 2,
  parameter int unsigned NUM_BANKS  = 2,
  parameter int unsigned INDEX_BITS = 6
);
  import ic_cfg_pkg::*;

  logic     [NUM_BANKS-1:0][NUM_WAYS-1:0]   bank_wren;     // Way strobes per bank
  logic     [NUM_BANKS-1:0][INDEX_BITS-1:0] bank_addr;     // Row per bank
  ic_word_t [NUM_BANKS-1:0]                 bank_wr_data;  // Write word per bank
  ic_word_t [NUM_WAYS-1:0][NUM_BANKS-1:0]   bank_rd_data;  // Registered read out

  modport ctrl (
    output bank_wren,
    output bank_addr,
    output bank_wr_data,
    input  bank_rd_data
  );

  modport array (
    input  bank_wren,
    input  bank_addr,
    input  bank_wr_data,
    output bank_rd_data
  );

endinterface

//--- common/ic_ecc_pkg.sv
package ic_ecc_pkg;
  import ic_cfg_pkg::*;

  localparam int unsigned IC_ECC_W = IC_WORD_W - IC_DATA_W;  // 7 check bits
  localparam int unsigned IC_HAM_W = IC_ECC_W - 1;           // Hamming part

  typedef logic [IC_ECC_W-1:0] ic_ecc_t;

  // Data bits sit at the non power-of-two code positions 3 to 71.
  // Check bit j covers every data position with bit j set, and the top
  // check bit is parity over data and the Hamming bits together.
  function automatic ic_ecc_t ic_ecc_encode(input ic_data_t data);
    ic_ecc_t ecc;
    int unsigned idx;
    ecc = '0;
    idx = 0;
    for (int unsigned pos = 3; pos <= IC_WORD_W; pos++) begin
      if ((pos & (pos - 1)) != 0) begin  // Skip check positions
        for (int unsigned j = 0; j < IC_HAM_W; j++) begin
          if (pos[j]) begin
            ecc[j] = ecc[j] ^ data[idx];
          end
        end
        idx++;
      end
    end
    ecc[IC_HAM_W] = ^{ecc[IC_HAM_W-1:0], data};  // Overall parity
    return ecc;
  endfunction

  // Zero for a clean word, any single flipped bit gives a nonzero result
  function automatic ic_ecc_t ic_ecc_syndrome(input ic_word_t word);
    ic_ecc_t chk;
    ic_ecc_t syn;
    chk = ic_ecc_encode(word[IC_DATA_W-1:0]);
    syn[IC_HAM_W-1:0] = chk[IC_HAM_W-1:0] ^ word[IC_DATA_W +: IC_HAM_W];
    syn[IC_HAM_W] = ^word;  // Whole word parity
    return syn;
  endfunction

endpackage

//--- common/ic_cfg_pkg.sv
package ic_cfg_pkg;

  // Bank word layout, data low and check bits on top
  localparam int unsigned IC_DATA_W = 64;
  localparam int unsigned IC_WORD_W = 71;

  // Default geometry, the wrapper passes the live values down
  localparam int unsigned IC_NUM_WAYS   = 2;
  localparam int unsigned IC_NUM_BANKS  = 2;
  localparam int unsigned IC_INDEX_BITS = 6;

  // Fetch address split
  localparam int unsigned IC_BANK_BIT = 3;                 // Bank select
  localparam int unsigned IC_INDEX_LO = IC_BANK_BIT + 1;   // First index bit

  typedef logic [IC_WORD_W-1:0] ic_word_t;   // Data plus ECC
  typedef logic [IC_DATA_W-1:0] ic_data_t;   // Fetch data

endpackage
